// File: include/ps_pio_cfg.svh
`ifndef PS_PIO_CFG_SVH
`define PS_PIO_CFG_SVH

// command bus decode
`define PS_PIO_ADDR         16'h100  // channel base on the command bus
`define PS_PIO_MASK         16'h3e0  // address bits compared to base

// register offsets within the channel
`define PS_PIO_REG_EN_RST   5'h0     // bit0 run, bit1 request enable
`define PS_PIO_REG_CMD      5'h1     // queue a sequencer command
`define PS_PIO_REG_STATUS   5'h2     // ask for a status packet

// status link
`define PS_PIO_STATUS_ADDR  8'h2     // first byte of every packet

// command queue
`define PS_PIO_FIFO_DEPTH   4        // entries, power of two

`endif

// File: design/ps_pio_pkg.sv
`include "ps_pio_cfg.svh"

package ps_pio_pkg;

    typedef logic [9:0]  seq_addr_t;     // sequencer program start
    typedef logic [1:0]  page_t;         // buffer page
    typedef logic [63:0] mem_word_t;     // memory side word
    typedef logic [31:0] ext_word_t;     // external side word

    typedef struct packed {
        logic      chn;                  // 0 read channel, 1 write channel
        logic      need;                 // urgent request
        page_t     page;                 // buffer page for this transfer
        seq_addr_t seq_addr;             // sequencer address
    } cmd_word_t;

    typedef struct packed {
        logic half_full;                 // queue at least half full
        logic pending;                   // queued or running
    } status_t;

    typedef enum logic [4:0] {
        reg_en_rst = `PS_PIO_REG_EN_RST,
        reg_cmd    = `PS_PIO_REG_CMD,
        reg_status = `PS_PIO_REG_STATUS
    } reg_op_e;

    typedef enum logic [2:0] {
        ds_idle,
        ds_addr_hi,
        ds_data0,
        ds_data1,
        ds_data2,
        ds_data3
    } deser_state_e;

    typedef enum logic [1:0] {
        st_idle,
        st_send_addr,
        st_send_data
    } status_state_e;

endpackage

// File: design/cmd_deser.sv
`include "ps_pio_cfg.svh"

module cmd_deser (
    input  logic                rst,      // clock
    input  logic                mclk,     // async reset, active low
    input  logic [7:0]          ad,       // byte-serial addr/data
    input  logic                stb,      // with first byte (AL)
    output ps_pio_pkg::reg_op_e addr,     // register offset in channel
    output logic [31:0]         data,     // assembled data word
    output logic                we        // one cycle after D3
);

    ps_pio_pkg::deser_state_e state;
    logic [15:0]              addr_r;     // {AH, AL}
    logic [31:0]              data_r;     // D3..D0, D0 in low byte
    logic                     match;

    // only the masked bits select this channel
    assign match = ((addr_r & `PS_PIO_MASK) == (`PS_PIO_ADDR & `PS_PIO_MASK));
    assign addr  = ps_pio_pkg::reg_op_e'(addr_r[4:0]);
    assign data  = data_r;

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            state <= ps_pio_pkg::ds_idle;
            we    <= 1'b0;
        end else begin
            we <= 1'b0;                   // default no write
            if (stb) begin
                state <= ps_pio_pkg::ds_addr_hi; // new frame, restarts any old one
            end else begin
                case (state)
                    ps_pio_pkg::ds_addr_hi: state <= ps_pio_pkg::ds_data0;
                    ps_pio_pkg::ds_data0:   state <= ps_pio_pkg::ds_data1;
                    ps_pio_pkg::ds_data1:   state <= ps_pio_pkg::ds_data2;
                    ps_pio_pkg::ds_data2:   state <= ps_pio_pkg::ds_data3;
                    ps_pio_pkg::ds_data3: begin
                        state <= ps_pio_pkg::ds_idle;
                        we    <= match;   // full address known here
                    end
                    default:                state <= ps_pio_pkg::ds_idle;
                endcase
            end
        end
    end

    always_ff @(posedge rst) begin
        if (stb) begin
            addr_r[7:0] <= ad;            // AL
        end else if (state == ps_pio_pkg::ds_addr_hi) begin
            addr_r[15:8] <= ad;           // AH
        end else if (state != ps_pio_pkg::ds_idle) begin
            data_r <= {ad, data_r[31:8]}; // shift in from top, lsb first
        end
    end

endmodule

// File: design/cmd_fifo.sv
`include "ps_pio_cfg.svh"

module cmd_fifo (
    input  logic                  rst,        // clock
    input  logic                  mclk,       // async reset, active low
    input  logic                  clr,        // sync clear
    input  logic                  push,
    input  logic                  pop,
    input  ps_pio_pkg::cmd_word_t din,
    output ps_pio_pkg::cmd_word_t dout,       // head entry
    output logic                  nempty,
    output logic                  half_full
);

    localparam int depth = `PS_PIO_FIFO_DEPTH;
    localparam int aw    = $clog2(depth);

    ps_pio_pkg::cmd_word_t mem [depth];
    logic [aw-1:0]         wptr;
    logic [aw-1:0]         rptr;
    logic [aw:0]           count;             // one extra bit for full
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full      = (count == (aw + 1)'(depth));
    assign nempty    = (count != '0);
    assign half_full = (count >= (aw + 1)'(depth / 2));
    assign do_push   = push && !full;         // drop when full
    assign do_pop    = pop && nempty;         // nothing to pop when empty
    assign dout      = mem[rptr];

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (clr) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push) wptr <= wptr + 1'b1;  // pointers wrap at depth
            if (do_pop)  rptr <= rptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

    always_ff @(posedge rst) begin
        if (do_push && !clr) mem[wptr] <= din;
    end

endmodule

// File: design/status_gen.sv
`include "ps_pio_cfg.svh"

module status_gen (
    input  logic                rst,      // clock
    input  logic                mclk,     // async reset, active low
    input  logic                send,     // status register write
    input  logic [5:0]          seq,      // sequence number from the write
    input  ps_pio_pkg::status_t status,   // live status payload
    output logic [7:0]          ad,       // byte to the status ring
    output logic                rq,       // high while address byte waits
    input  logic                start     // address byte accepted
);

    ps_pio_pkg::status_state_e state;
    logic [5:0]                seq_r;
    ps_pio_pkg::status_t       status_r;  // sampled on start

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            state <= ps_pio_pkg::st_idle;
        end else begin
            case (state)
                ps_pio_pkg::st_idle: begin
                    if (send) state <= ps_pio_pkg::st_send_addr;
                end
                ps_pio_pkg::st_send_addr: begin
                    if (start) state <= ps_pio_pkg::st_send_data; // wait as long as needed
                end
                ps_pio_pkg::st_send_data: state <= ps_pio_pkg::st_idle;
                default:                  state <= ps_pio_pkg::st_idle;
            endcase
        end
    end

    // send while busy is dropped, seq kept from the first request
    always_ff @(posedge rst) begin
        if (send && (state == ps_pio_pkg::st_idle)) seq_r <= seq;
        if (start && (state == ps_pio_pkg::st_send_addr)) status_r <= status;
    end

    assign rq = (state == ps_pio_pkg::st_send_addr);

    always_comb begin
        case (state)
            ps_pio_pkg::st_send_addr: ad = `PS_PIO_STATUS_ADDR;
            ps_pio_pkg::st_send_data: ad = {seq_r, status_r}; // last byte, rq low
            default:                  ad = 8'h00;
        endcase
    end

endmodule

// File: design/ps_pio_ctrl.sv
module ps_pio_ctrl (
    input  logic                  rst,             // clock
    input  logic                  mclk,            // async reset, active low
    input  ps_pio_pkg::reg_op_e   op,              // decoded register offset
    input  logic [31:0]           data,
    input  logic                  we,
    output logic                  push,            // queue a command
    output logic                  clr,             // empty the queue
    output logic                  pop,
    input  ps_pio_pkg::cmd_word_t head,            // oldest queued command
    input  logic                  nempty,
    input  logic                  half_full,
    output logic                  status_send,
    output ps_pio_pkg::status_t   status,
    output logic                  want_rq0,
    output logic                  need_rq0,
    output logic                  want_rq1,
    output logic                  need_rq1,
    input  logic                  channel_pgm_en0, // grant, read channel
    input  logic                  channel_pgm_en1, // grant, write channel
    input  logic                  seq_done0,
    input  logic                  seq_done1,
    output ps_pio_pkg::seq_addr_t seq_data,
    output logic                  seq_set,
    output ps_pio_pkg::page_t     page,
    output logic                  page_set         // load page into buffer
);

    logic [1:0] en_reset;      // bit0 run, bit1 request enable
    logic       chn_rst;
    logic       chn_en;
    logic       grant;
    logic       done;
    logic       mem_run;       // granted, transfer in progress
    logic       busy;
    logic       start;
    logic       set_en_rst;

    assign set_en_rst  = we && (op == ps_pio_pkg::reg_en_rst);
    assign push        = we && (op == ps_pio_pkg::reg_cmd);
    assign status_send = we && (op == ps_pio_pkg::reg_status);

    assign chn_rst  = ~en_reset[0];
    assign chn_en   = en_reset[1];
    assign clr      = chn_rst;           // queue held empty in reset
    assign pop      = seq_set;           // head consumed with the hand-off
    assign grant    = channel_pgm_en0 | channel_pgm_en1;
    assign done     = seq_done0 | seq_done1;
    assign busy     = want_rq0 | need_rq0 | want_rq1 | need_rq1 | mem_run;
    assign start    = chn_en && !chn_rst && !busy && nempty;
    assign seq_data = head.seq_addr;     // valid while seq_set is high

    assign status.half_full = half_full;
    assign status.pending   = nempty | busy;

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            en_reset <= 2'b00;            // held in reset, disabled
            want_rq0 <= 1'b0;
            need_rq0 <= 1'b0;
            want_rq1 <= 1'b0;
            need_rq1 <= 1'b0;
            mem_run  <= 1'b0;
            seq_set  <= 1'b0;
            page     <= '0;
            page_set <= 1'b0;
        end else begin
            if (set_en_rst) en_reset <= data[1:0];

            if (chn_rst || grant) begin
                want_rq0 <= 1'b0;         // drop on reset or grant
                need_rq0 <= 1'b0;
                want_rq1 <= 1'b0;
                need_rq1 <= 1'b0;
            end else if (start) begin
                want_rq0 <= !head.chn;
                need_rq0 <= !head.chn && head.need;
                want_rq1 <= head.chn;
                need_rq1 <= head.chn && head.need;
            end

            if (chn_rst || done) mem_run <= 1'b0;
            else if (grant)      mem_run <= 1'b1;

            seq_set  <= grant && !chn_rst; // one cycle after grant
            page_set <= seq_set;           // one cycle after seq_set
            if (seq_set) page <= head.page;
        end
    end

endmodule

// File: design/page_buf_rd.sv
module page_buf_rd (
    input  logic                  rst,        // clock
    input  logic                  mclk,       // async reset, active low
    input  logic                  wr,         // memory side write
    input  ps_pio_pkg::mem_word_t wdata,
    input  ps_pio_pkg::page_t     page_in,    // page from the command
    input  logic                  page_set,
    input  logic                  page_next,  // advance page, mod 4
    input  logic                  re,         // capture word at raddr
    input  logic                  regen,      // load output register
    input  logic [9:0]            raddr,      // {page, word, half}
    output ps_pio_pkg::ext_word_t rdata
);

    ps_pio_pkg::mem_word_t mem [512];     // 4 pages of 128 words
    ps_pio_pkg::page_t     page;          // write page
    logic [6:0]            cnt;           // word within page
    ps_pio_pkg::mem_word_t rword;
    ps_pio_pkg::ext_word_t cap;           // captured half word
    ps_pio_pkg::ext_word_t out_r;

    assign rword = mem[raddr[9:1]];
    assign rdata = out_r;

    always_ff @(posedge rst or negedge mclk) begin
        if (!mclk) begin
            page <= '0;
            cnt  <= '0;
        end else if (page_set) begin
            page <= page_in;
            cnt  <= '0;
        end else if (page_next) begin
            page <= page + 1'b1;          // wraps after page 3
            cnt  <= '0;
        end else if (wr) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge rst) begin
        if (wr)    mem[{page, cnt}] <= wdata;
        if (re)    cap <= raddr[0] ? rword[63:32] : rword[31:0]; // even is low half
        if (regen) out_r <= cap;
    end

endmodule

// File: design/ps_pio_top.sv
module ps_pio_top (
    input  logic                  rst,             // clock
    input  logic                  mclk,            // async reset, active low
    input  logic [7:0]            cmd_ad,
    input  logic                  cmd_stb,
    output logic [7:0]            status_ad,
    output logic                  status_rq,
    input  logic                  status_start,
    output logic                  want_rq0,
    output logic                  need_rq0,
    output logic                  want_rq1,
    output logic                  need_rq1,
    input  logic                  channel_pgm_en0,
    input  logic                  channel_pgm_en1,
    input  logic                  seq_done0,
    input  logic                  seq_done1,
    output ps_pio_pkg::seq_addr_t seq_data,        // shared by both channels
    output logic                  seq_set,
    input  logic                  buf_wr,
    input  ps_pio_pkg::mem_word_t buf_wdata,
    input  logic                  buf_wpage_nxt,
    input  logic                  port_re,
    input  logic                  port_regen,
    input  logic [9:0]            port_addr,
    output ps_pio_pkg::ext_word_t port_data
);

    ps_pio_pkg::reg_op_e   cmd_op;
    logic [31:0]           cmd_data;
    logic                  cmd_we;
    logic                  fifo_push;
    logic                  fifo_clr;
    logic                  fifo_pop;
    ps_pio_pkg::cmd_word_t fifo_head;
    logic                  fifo_nempty;
    logic                  fifo_half_full;
    logic                  status_send;
    ps_pio_pkg::status_t   status;
    ps_pio_pkg::page_t     page;           // latched at hand-off
    logic                  page_set;

    cmd_deser cmd_deser_inst (
        .rst  (rst),
        .mclk (mclk),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (cmd_op),
        .data (cmd_data),
        .we   (cmd_we)
    );

    cmd_fifo cmd_fifo_inst (
        .rst       (rst),
        .mclk      (mclk),
        .clr       (fifo_clr),
        .push      (fifo_push),
        .pop       (fifo_pop),
        .din       (ps_pio_pkg::cmd_word_t'(cmd_data[13:0])), // command fields only
        .dout      (fifo_head),
        .nempty    (fifo_nempty),
        .half_full (fifo_half_full)
    );

    status_gen status_gen_inst (
        .rst    (rst),
        .mclk   (mclk),
        .send   (status_send),
        .seq    (cmd_data[5:0]),              // low data byte tags the packet
        .status (status),
        .ad     (status_ad),
        .rq     (status_rq),
        .start  (status_start)
    );

    ps_pio_ctrl ps_pio_ctrl_inst (
        .rst             (rst),
        .mclk            (mclk),
        .op              (cmd_op),
        .data            (cmd_data),
        .we              (cmd_we),
        .push            (fifo_push),
        .clr             (fifo_clr),
        .pop             (fifo_pop),
        .head            (fifo_head),
        .nempty          (fifo_nempty),
        .half_full       (fifo_half_full),
        .status_send     (status_send),
        .status          (status),
        .want_rq0        (want_rq0),
        .need_rq0        (need_rq0),
        .want_rq1        (want_rq1),
        .need_rq1        (need_rq1),
        .channel_pgm_en0 (channel_pgm_en0),
        .channel_pgm_en1 (channel_pgm_en1),
        .seq_done0       (seq_done0),
        .seq_done1       (seq_done1),
        .seq_data        (seq_data),
        .seq_set         (seq_set),
        .page            (page),
        .page_set        (page_set)
    );

    // read channel buffer, memory writes in, port reads out
    page_buf_rd page_buf_rd_inst (
        .rst       (rst),
        .mclk      (mclk),
        .wr        (buf_wr),
        .wdata     (buf_wdata),
        .page_in   (page),
        .page_set  (page_set),
        .page_next (buf_wpage_nxt),
        .re        (port_re),
        .regen     (port_regen),
        .raddr     (port_addr),
        .rdata     (port_data)
    );

endmodule

// File: dv/ps_pio_tb.sv
`include "ps_pio_cfg.svh"

module ps_pio_tb;

    logic                  rst;            // clock
    logic                  mclk;           // reset, active low
    logic [7:0]            cmd_ad;
    logic                  cmd_stb;
    logic [7:0]            status_ad;
    logic                  status_rq;
    logic                  status_start;
    wire  [3:0]            req;            // {want_rq1, need_rq1, want_rq0, need_rq0}
    logic [1:0]            pgm_en;         // grants, bit per channel
    logic [1:0]            seq_done;
    ps_pio_pkg::seq_addr_t seq_data;
    logic                  seq_set;
    logic                  buf_wr;
    ps_pio_pkg::mem_word_t buf_wdata;
    logic                  buf_wpage_nxt;
    logic                  port_re;
    logic                  port_regen;
    logic [9:0]            port_addr;
    ps_pio_pkg::ext_word_t port_data;
    ps_pio_pkg::mem_word_t exp_mem [512];  // buffer model, {page, word}
    ps_pio_pkg::page_t     wr_page;        // model of the write page
    logic [6:0]            wr_cnt;
    logic [31:0]           lcg;
    int                    errors;
    int                    checks;
    int                    tests;

    ps_pio_top ps_pio_top_inst (
        .rst (rst), .mclk (mclk), .cmd_ad (cmd_ad), .cmd_stb (cmd_stb),
        .status_ad (status_ad), .status_rq (status_rq), .status_start (status_start),
        .want_rq0 (req[1]), .need_rq0 (req[0]), .want_rq1 (req[3]), .need_rq1 (req[2]),
        .channel_pgm_en0 (pgm_en[0]), .channel_pgm_en1 (pgm_en[1]),
        .seq_done0 (seq_done[0]), .seq_done1 (seq_done[1]),
        .seq_data (seq_data), .seq_set (seq_set), .buf_wr (buf_wr), .buf_wdata (buf_wdata),
        .buf_wpage_nxt (buf_wpage_nxt), .port_re (port_re), .port_regen (port_regen),
        .port_addr (port_addr), .port_data (port_data)
    );

    always #10 rst = ~rst;                 // 20 unit period

    function automatic logic [31:0] lcg_next();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    task automatic check_seq(input string name, input ps_pio_pkg::seq_addr_t got,
                             input ps_pio_pkg::seq_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input ps_pio_pkg::ext_word_t got,
                              input ps_pio_pkg::ext_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic send_frame(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};              // AL in the low byte
        for (int i = 0; i < 6; i++) begin
            @(negedge rst);
            cmd_stb = (i == 0);            // strobe only with AL
            cmd_ad  = bytes[8*i +: 8];
        end
        @(negedge rst);
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
    endtask

    task automatic run_grant(input logic chn, input logic [3:0] exp_req,
                             input ps_pio_pkg::seq_addr_t exp_seq, input ps_pio_pkg::page_t pg);
        int n;
        for (n = 0; n < 50 && req == 4'b0; n++) @(negedge rst);
        if (req == 4'b0) report_timeout("no request came up before the grant");
        check_req("want/need", req, exp_req);
        pgm_en[chn] = 1'b1;                // one cycle grant
        @(negedge rst);
        pgm_en = 2'b00;
        check_req("want/need after grant", req, 4'b0);
        for (n = 0; n < 10 && !seq_set; n++) @(negedge rst);
        if (!seq_set) report_timeout("seq_set did not pulse after the grant");
        else check_seq("seq_data", seq_data, exp_seq);
        repeat (2) @(negedge rst);         // page_set follows, then page is loaded
        wr_page = pg;
        wr_cnt  = '0;
    endtask

    task automatic write_burst(input int cnt);
        for (int i = 0; i < cnt; i++) begin
            buf_wdata = {lcg_next(), lcg_next()};
            buf_wr    = 1'b1;
            exp_mem[{wr_page, wr_cnt}] = buf_wdata;
            wr_cnt++;
            @(negedge rst);
        end
        buf_wr = 1'b0;
    endtask

    task automatic read_port(input logic [9:0] addr);
        ps_pio_pkg::mem_word_t word;
        port_addr = addr;
        port_re   = 1'b1;                  // capture
        @(negedge rst);
        port_re    = 1'b0;
        port_regen = 1'b1;                 // load output reg
        @(negedge rst);
        port_regen = 1'b0;
        word = exp_mem[addr[9:1]];
        check_word("port_data", port_data, addr[0] ? word[63:32] : word[31:0]);
    endtask

    task automatic request_status(input logic [5:0] seq, input ps_pio_pkg::status_t st);
        int n;
        send_frame(`PS_PIO_ADDR + `PS_PIO_REG_STATUS, {26'h0, seq});
        for (n = 0; n < 20 && !status_rq; n++) @(negedge rst);
        if (!status_rq) report_timeout("status_rq never rose");
        check_status("status_ad addr byte", status_ad, `PS_PIO_STATUS_ADDR);
        status_start = 1'b1;
        @(negedge rst);
        status_start = 1'b0;
        if (status_rq) begin
            errors++;
            $display("status_rq still high after status_start");
        end
        check_status("status_ad data byte", status_ad, {seq, st});
        @(negedge rst);                    // back to idle
    endtask

    initial begin
        int          fd;
        int          n;
        int          e0;
        logic [7:0]  op;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [8*128-1:0] skip_line;
        rst = 1'b0;
        mclk = 1'b0;
        cmd_ad = 8'h00;
        cmd_stb = 1'b0;
        status_start = 1'b0;
        pgm_en = 2'b00;
        seq_done = 2'b00;
        buf_wr = 1'b0;
        buf_wdata = '0;
        buf_wpage_nxt = 1'b0;
        port_re = 1'b0;
        port_regen = 1'b0;
        port_addr = '0;
        lcg = 32'h98ad;
        wr_page = '0;
        wr_cnt = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        repeat (8) @(negedge rst);
        mclk = 1'b1;                       // out of reset
        fd = $fopen("dv/ps_pio_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            while (1) begin
                n = $fscanf(fd, " %c", op);
                if (n != 1) break;
                if (op == "#") begin
                    n = $fgets(skip_line, fd);  // comment line
                    continue;
                end
                e0 = errors;
                case (op)
                    "W": begin
                        n = $fscanf(fd, "%h %h", f0, f1);
                        send_frame(f0[15:0], f1);
                    end
                    "Q": begin
                        n = $fscanf(fd, "%h", f0);
                        repeat (4) @(negedge rst);   // enough for queue and request
                        check_req("want/need idle", req, f0[3:0]);
                    end
                    "G": begin
                        n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                        run_grant(f0[0], f1[3:0], f2[9:0], f3[1:0]);
                    end
                    "D": begin
                        n = $fscanf(fd, "%h", f0);
                        seq_done[f0[0]] = 1'b1;
                        @(negedge rst);
                        seq_done = 2'b00;
                    end
                    "B": begin
                        n = $fscanf(fd, "%h", f0);
                        write_burst(f0);
                    end
                    "P": begin
                        buf_wpage_nxt = 1'b1;
                        @(negedge rst);
                        buf_wpage_nxt = 1'b0;
                        wr_page++;                   // wraps mod 4
                        wr_cnt = '0;
                    end
                    "R": begin
                        n = $fscanf(fd, "%h", f0);
                        read_port(f0[9:0]);
                    end
                    "S": begin
                        n = $fscanf(fd, "%h %h", f0, f1);
                        request_status(f0[5:0], ps_pio_pkg::status_t'(f1[1:0]));
                    end
                    default: begin
                        errors++;
                        $display("unknown opcode %c in the stimulus file", op);
                    end
                endcase
                tests++;
                $display("test %0d op %c: %s", tests, op, (errors == e0) ? "ok" : "failed");
            end
            $fclose(fd);
        end
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: dv/ps_pio_stim.txt
# op and hex fields: W addr data | Q req | G chn req seq page | D chn | B count | P
# R port_addr | S seq status ; req = {want1,need1,want0,need0}, status = {half_full,pending}
W 0100 00000001
W 0101 000014a5
Q 0
W 0100 00000003
G 0 3 0a5 1
B 8
R 100
R 101
R 10e
P
B 4
R 200
R 207
D 0
W 0101 00002d55
W 0101 000003ff
G 1 8 155 3
B 2
R 300
R 303
D 1
G 0 2 3ff 0
D 0
# other base address, must be ignored
W 0201 000014a5
Q 0
S 05 0
W 0100 00000001
W 0101 000014a5
W 0101 000014a5
W 0101 000014a5
S 2a 3
W 0100 00000003
Q 3
W 0100 00000000
Q 0
S 11 0

// File: src.f
+incdir+include
design/ps_pio_pkg.sv
design/cmd_deser.sv
design/cmd_fifo.sv
design/status_gen.sv
design/ps_pio_ctrl.sv
design/page_buf_rd.sv
design/ps_pio_top.sv
dv/ps_pio_tb.sv
